// File: src/l2c_defs.svh
// ####################################################################
// // shared constants of the level-2 controller address initializer
// // lane count, address width, depthwise geometry and layer codes
// // include after the net type line, before the package or module
// ####################################################################

`ifndef L2C_DEFS_SVH
`define L2C_DEFS_SVH

// lanes per FIFO bank (ifmap, ipsum, opsum each)
`define L2C_NUM_LANES 32

// global-buffer address width
`define L2C_ADDR_W 32

// all-zero padding region, read for rows above the image top
`define L2C_ZERO_ZONE 32'h1000_0000

// depthwise 3x3 tiling
// 10 channels by 3 kernel rows fill lanes 0..29
`define L2C_DW_CH 10
`define L2C_DW_ROWS 3

// layer type codes from the scheduler
// codes 2 and 3 (standard, linear) are not handled here
`define L2C_PW 2'd0
`define L2C_DW 2'd1

`endif

// File: src/l2c_pkg.sv
// ####################################################################
// // types shared by the address initializer and its testbench
// // refer to them by scoped name, e.g. l2c_pkg::addr_t
// ####################################################################

`default_nettype none

`include "l2c_defs.svh"

package l2c_pkg;

    // one global-buffer address
    typedef logic [`L2C_ADDR_W-1:0] addr_t;

    // layer type code, see L2C_PW / L2C_DW
    typedef logic [1:0] layer_t;

    // channel count of the tile
    typedef logic [7:0] chan_t;

    // tile dimension or per-bank stride
    typedef logic [31:0] dim_t;

    // output row counter, signed so row-1 can go negative
    typedef logic signed [31:0] row_t;

    // full bank of lane base addresses, lane 0 in the low word
    typedef addr_t [`L2C_NUM_LANES-1:0] addr_bank_t;

    // tile configuration from the layer scheduler
    typedef struct packed {
        layer_t layer_type;
        dim_t   tile_n;
        chan_t  in_c;
        dim_t   on_real;
        row_t   out_row;
    } tile_cfg_t;

    // FIFO group reset strobes
    typedef struct packed {
        logic ifmap;
        logic ipsum;
        logic opsum;
    } fifo_rst_t;

endpackage

`default_nettype wire

// File: src/ifmap_base_addr_gen.sv
// ####################################################################
// // ifmap lane base-address bank
// // loads on every edge of the init state for pointwise and
// // depthwise layers, holds its bank otherwise
// // depthwise rows above the image top point to the zero zone
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

`include "l2c_defs.svh"

module ifmap_base_addr_gen (
    input  wire logic               clk,
    input  wire logic               rst_n,
    // level, high for the whole init state
    input  wire logic               init_i,
    input  wire l2c_pkg::tile_cfg_t cfg_i,
    // ifmap region start in the global buffer
    input  wire l2c_pkg::addr_t     base_i,
    output l2c_pkg::addr_bank_t     bank_o
);

    // next bank contents, all lanes in parallel
    l2c_pkg::addr_bank_t bank_d;
    // only the two kept layer types update the bank
    logic                load_en;

    assign load_en = init_i &&
                     ((cfg_i.layer_type == `L2C_PW) || (cfg_i.layer_type == `L2C_DW));

    always_comb begin
        bank_d = '0;
        for (int lane = 0; lane < `L2C_NUM_LANES; lane++) begin
            l2c_pkg::addr_t ch_idx;
            l2c_pkg::addr_t row_idx;
            l2c_pkg::row_t  src_row;
            l2c_pkg::addr_t ch_off;
            l2c_pkg::addr_t row_off;

            // lane = 3*channel + kernel row in depthwise mode
            ch_idx  = l2c_pkg::addr_t'(lane / `L2C_DW_ROWS);
            row_idx = l2c_pkg::addr_t'(lane % `L2C_DW_ROWS);
            // kernel row 0 reads the row above the output row
            src_row = cfg_i.out_row + l2c_pkg::row_t'(row_idx) - l2c_pkg::row_t'(1);
            // one channel plane is tile_n rows of in_c words
            ch_off  = ch_idx * cfg_i.tile_n * l2c_pkg::addr_t'(cfg_i.in_c);
            row_off = l2c_pkg::addr_t'(src_row) * l2c_pkg::addr_t'(cfg_i.in_c);

            case (cfg_i.layer_type)
                `L2C_PW: begin
                    // one input channel per lane, tile_n apart
                    bank_d[lane] = base_i + l2c_pkg::addr_t'(lane) * cfg_i.tile_n;
                end
                `L2C_DW: begin
                    if (lane < `L2C_DW_CH * `L2C_DW_ROWS) begin
                        // top padding, signed test on the source row
                        if (src_row < 0) begin
                            bank_d[lane] = `L2C_ZERO_ZONE;
                        end else begin
                            bank_d[lane] = base_i + ch_off + row_off;
                        end
                    end else begin
                        // lanes 30 and 31 idle in depthwise
                        bank_d[lane] = '0;
                    end
                end
                default: begin
                    // not loaded, see load_en
                    bank_d[lane] = '0;
                end
            endcase
        end
    end

    // bank register
    // holds between tiles so the ifmap FIFOs keep their pointers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bank_o <= '0;
        end else if (load_en) begin
            bank_o <= bank_d;
        end
    end

endmodule

`default_nettype wire

// File: src/psum_base_addr_gen.sv
// ####################################################################
// // partial-sum lane base-address bank, used for ipsum and opsum
// // stride_i sets the lane pitch: tile_n for ipsum, on_real for opsum
// // the bank is valid only one edge after init, zero otherwise
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

`include "l2c_defs.svh"

module psum_base_addr_gen (
    input  wire logic               clk,
    input  wire logic               rst_n,
    // level, high for the whole init state
    input  wire logic               init_i,
    input  wire l2c_pkg::tile_cfg_t cfg_i,
    // psum region start, bias base already selected upstream
    input  wire l2c_pkg::addr_t     base_i,
    // per-bank lane pitch
    input  wire l2c_pkg::dim_t      stride_i,
    output l2c_pkg::addr_bank_t     bank_o
);

    // next bank contents
    // stays zero for the unhandled layer types
    l2c_pkg::addr_bank_t bank_d;

    always_comb begin
        bank_d = '0;
        for (int lane = 0; lane < `L2C_NUM_LANES; lane++) begin
            l2c_pkg::addr_t ch_idx;
            l2c_pkg::addr_t row_idx;

            ch_idx  = l2c_pkg::addr_t'(lane / `L2C_DW_ROWS);
            row_idx = l2c_pkg::addr_t'(lane % `L2C_DW_ROWS);

            case (cfg_i.layer_type)
                `L2C_PW: begin
                    // one output channel per lane
                    bank_d[lane] = base_i + l2c_pkg::addr_t'(lane) * stride_i;
                end
                `L2C_DW: begin
                    if (lane < `L2C_DW_CH * `L2C_DW_ROWS) begin
                        // fixed rows 0..2, no padding on the psum side
                        bank_d[lane] = base_i
                                     + ch_idx * stride_i * l2c_pkg::addr_t'(cfg_i.in_c)
                                     + row_idx * l2c_pkg::addr_t'(cfg_i.in_c);
                    end else begin
                        bank_d[lane] = '0;
                    end
                end
                default: begin
                    bank_d[lane] = '0;
                end
            endcase
        end
    end

    // bank register
    // cleared outside init so the psum FIFOs never see a stale pointer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bank_o <= '0;
        end else if (init_i) begin
            bank_o <= bank_d;
        end else begin
            bank_o <= '0;
        end
    end

endmodule

`default_nettype wire

// File: src/l2c_fifo_base_init.sv
// ####################################################################
// // FIFO base-address initializer of the level-2 controller
// // driven by the scheduler's init state; computes the ifmap, ipsum
// // and opsum lane base addresses one cycle after init is seen and
// // pulses the three FIFO-group resets for as long as init lasts
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

`include "l2c_defs.svh"

module l2c_fifo_base_init (
    input  wire logic               clk,
    input  wire logic               rst_n,

    // scheduler side
    // init_i is a level, no handshake
    input  wire logic               init_i,
    input  wire l2c_pkg::tile_cfg_t cfg_i,

    // region starts in the global buffer
    input  wire l2c_pkg::addr_t     ifmap_base_i,
    input  wire l2c_pkg::addr_t     ipsum_base_i,
    input  wire l2c_pkg::addr_t     bias_base_i,
    input  wire l2c_pkg::addr_t     opsum_base_i,
    // first pass of a tile reads bias instead of ipsum
    input  wire logic               is_bias_i,

    // lane base addresses to the FIFO banks
    output l2c_pkg::addr_bank_t     ifmap_bank_o,
    output l2c_pkg::addr_bank_t     ipsum_bank_o,
    output l2c_pkg::addr_bank_t     opsum_bank_o,

    // FIFO group resets
    output l2c_pkg::fifo_rst_t      fifo_rst_o
);

    // ipsum bank start, bias or running partial sums
    l2c_pkg::addr_t ipsum_sel_base;

    assign ipsum_sel_base = is_bias_i ? bias_base_i : ipsum_base_i;

    // reset strobes
    // same cycle as init, all three groups together
    assign fifo_rst_o.ifmap = init_i;
    assign fifo_rst_o.ipsum = init_i;
    assign fifo_rst_o.opsum = init_i;

    // ifmap bank, holds between tiles
    ifmap_base_addr_gen u_ifmap_gen (
        .clk    (clk),
        .rst_n  (rst_n),
        .init_i (init_i),
        .cfg_i  (cfg_i),
        .base_i (ifmap_base_i),
        .bank_o (ifmap_bank_o)
    );

    // ipsum bank
    // walks by tile width
    psum_base_addr_gen u_ipsum_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .init_i   (init_i),
        .cfg_i    (cfg_i),
        .base_i   (ipsum_sel_base),
        .stride_i (cfg_i.tile_n),
        .bank_o   (ipsum_bank_o)
    );

    // opsum bank
    // walks by real output width, edge tiles are narrower
    psum_base_addr_gen u_opsum_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .init_i   (init_i),
        .cfg_i    (cfg_i),
        .base_i   (opsum_base_i),
        .stride_i (cfg_i.on_real),
        .bank_o   (opsum_bank_o)
    );

endmodule

`default_nettype wire

// File: verification/l2c_ref_model.svh
// ####################################################################
// // expected lane base addresses for the address initializer testbench
// // included inside the testbench module, works on 64-bit integers
// // and wraps to the 32-bit address at the end
// ####################################################################

`ifndef L2C_REF_MODEL_SVH
`define L2C_REF_MODEL_SVH

`include "l2c_defs.svh"

// ifmap lane, only meaningful for pointwise and depthwise
function automatic l2c_pkg::addr_t ref_ifmap_lane(
    input l2c_pkg::tile_cfg_t cfg,
    input l2c_pkg::addr_t     base,
    input int                 lane
);
    longint ch;
    longint row;
    longint src_row;
    longint addr;

    // depthwise lane = channel * 3 + kernel row
    ch      = lane / `L2C_DW_ROWS;
    row     = lane % `L2C_DW_ROWS;
    // out_row is signed, so the source row can go below zero
    src_row = longint'(cfg.out_row) + row - 1;
    addr    = 0;
    if (cfg.layer_type == `L2C_PW) begin
        addr = longint'(base) + longint'(lane) * longint'(cfg.tile_n);
    end else if (lane < `L2C_DW_CH * `L2C_DW_ROWS) begin
        if (src_row < 0) begin
            // above the image top
            addr = longint'(`L2C_ZERO_ZONE);
        end else begin
            addr = longint'(base)
                 + ch * longint'(cfg.tile_n) * longint'(cfg.in_c)
                 + src_row * longint'(cfg.in_c);
        end
    end
    return l2c_pkg::addr_t'(addr);
endfunction

// psum lane, zero for the idle depthwise lanes and other layer types
function automatic l2c_pkg::addr_t ref_psum_lane(
    input l2c_pkg::tile_cfg_t cfg,
    input l2c_pkg::addr_t     base,
    input l2c_pkg::dim_t      stride,
    input int                 lane
);
    longint addr;

    addr = 0;
    if (cfg.layer_type == `L2C_PW) begin
        addr = longint'(base) + longint'(lane) * longint'(stride);
    end else if (cfg.layer_type == `L2C_DW && lane < `L2C_DW_CH * `L2C_DW_ROWS) begin
        addr = longint'(base)
             + longint'(lane / `L2C_DW_ROWS) * longint'(stride) * longint'(cfg.in_c)
             + longint'(lane % `L2C_DW_ROWS) * longint'(cfg.in_c);
    end
    return l2c_pkg::addr_t'(addr);
endfunction

// whole ifmap bank after an init edge, prev is kept for other layer types
function automatic l2c_pkg::addr_bank_t ref_ifmap_bank(
    input l2c_pkg::tile_cfg_t  cfg,
    input l2c_pkg::addr_t      base,
    input l2c_pkg::addr_bank_t prev
);
    l2c_pkg::addr_bank_t bank;

    bank = prev;
    if (cfg.layer_type == `L2C_PW || cfg.layer_type == `L2C_DW) begin
        for (int lane = 0; lane < `L2C_NUM_LANES; lane++) begin
            bank[lane] = ref_ifmap_lane(cfg, base, lane);
        end
    end
    return bank;
endfunction

// whole psum bank after an init edge
function automatic l2c_pkg::addr_bank_t ref_psum_bank(
    input l2c_pkg::tile_cfg_t cfg,
    input l2c_pkg::addr_t     base,
    input l2c_pkg::dim_t      stride
);
    l2c_pkg::addr_bank_t bank;

    for (int lane = 0; lane < `L2C_NUM_LANES; lane++) begin
        bank[lane] = ref_psum_lane(cfg, base, stride, lane);
    end
    return bank;
endfunction

`endif

// File: verification/tb_l2c_fifo_base_init.sv
// ####################################################################
// // testbench of the FIFO base-address initializer
// // walks a table of tiles through init, checks all 96 lanes and
// // the reset strobes, then prints a per-test line and a summary
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

`include "l2c_defs.svh"

module tb_l2c_fifo_base_init;

    localparam int          NUM_TESTS      = 9;
    localparam int          TIMEOUT_CYCLES = 20 * NUM_TESTS + 20;
    localparam logic [31:0] SEED           = 32'hee98cda3;

    // one row of the stimulus table
    typedef struct packed {
        l2c_pkg::layer_t layer_type;
        l2c_pkg::addr_t  ifmap_base;
        l2c_pkg::addr_t  ipsum_base;
        l2c_pkg::addr_t  bias_base;
        l2c_pkg::addr_t  opsum_base;
        logic            is_bias;
        l2c_pkg::dim_t   tile_n;
        l2c_pkg::chan_t  in_c;
        l2c_pkg::dim_t   on_real;
        l2c_pkg::row_t   out_row;
    } stim_t;

    logic                clk;
    logic                rst_n;
    logic                init;
    l2c_pkg::tile_cfg_t  cfg;
    l2c_pkg::addr_t      ifmap_base;
    l2c_pkg::addr_t      ipsum_base;
    l2c_pkg::addr_t      bias_base;
    l2c_pkg::addr_t      opsum_base;
    logic                is_bias;
    l2c_pkg::addr_bank_t ifmap_bank;
    l2c_pkg::addr_bank_t ipsum_bank;
    l2c_pkg::addr_bank_t opsum_bank;
    l2c_pkg::fifo_rst_t  fifo_rst;

    stim_t stim_table [NUM_TESTS];
    string stim_name  [NUM_TESTS];

    // expected bank contents
    // ifmap carries over between tiles
    l2c_pkg::addr_bank_t exp_ifmap;
    l2c_pkg::addr_bank_t exp_ipsum;
    l2c_pkg::addr_bank_t exp_opsum;

    int err_cnt;
    int fail_cnt;
    int cur_test;
    int cycle_cnt;

    `include "l2c_ref_model.svh"

    l2c_fifo_base_init i_l2c_fifo_base_init (
        .clk          (clk),
        .rst_n        (rst_n),
        .init_i       (init),
        .cfg_i        (cfg),
        .ifmap_base_i (ifmap_base),
        .ipsum_base_i (ipsum_base),
        .bias_base_i  (bias_base),
        .opsum_base_i (opsum_base),
        .is_bias_i    (is_bias),
        .ifmap_bank_o (ifmap_bank),
        .ipsum_bank_o (ipsum_bank),
        .opsum_bank_o (opsum_bank),
        .fifo_rst_o   (fifo_rst)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // watchdog counting clock edges up to the limit
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("mismatch %s in test %0d: got %h, expected %h", name, cur_test, got, exp);
        end
    endtask

    // all 96 lanes against the expected banks
    task automatic check_banks();
        for (int lane = 0; lane < `L2C_NUM_LANES; lane++) begin
            check_value($sformatf("ifmap_bank_o[%0d]", lane), ifmap_bank[lane], exp_ifmap[lane]);
            check_value($sformatf("ipsum_bank_o[%0d]", lane), ipsum_bank[lane], exp_ipsum[lane]);
            check_value($sformatf("opsum_bank_o[%0d]", lane), opsum_bank[lane], exp_opsum[lane]);
        end
    endtask

    // all three strobes follow init
    task automatic check_fifo_rst(input logic level);
        check_value("fifo_rst_o", {29'd0, fifo_rst}, level ? 32'h7 : 32'h0);
    endtask

    // table row with bases drawn at random
    task automatic add_entry(input int idx, input string name, input l2c_pkg::layer_t layer,
                             input logic bias, input l2c_pkg::dim_t tile_n,
                             input l2c_pkg::chan_t in_c, input l2c_pkg::dim_t on_real,
                             input l2c_pkg::row_t out_row);
        stim_name[idx]             = name;
        stim_table[idx].layer_type = layer;
        stim_table[idx].ifmap_base = $urandom;
        stim_table[idx].ipsum_base = $urandom;
        stim_table[idx].bias_base  = $urandom;
        stim_table[idx].opsum_base = $urandom;
        stim_table[idx].is_bias    = bias;
        stim_table[idx].tile_n     = tile_n;
        stim_table[idx].in_c       = in_c;
        stim_table[idx].on_real    = on_real;
        stim_table[idx].out_row    = out_row;
    endtask

    task automatic run_entry(input int idx);
        stim_t              s;
        l2c_pkg::tile_cfg_t c;
        int                 err_before;

        s          = stim_table[idx];
        cur_test   = idx + 1;
        err_before = err_cnt;
        c.layer_type = s.layer_type;
        c.tile_n     = s.tile_n;
        c.in_c       = s.in_c;
        c.on_real    = s.on_real;
        c.out_row    = s.out_row;

        // enter init with the new tile
        @(posedge clk);
        init       <= 1'b1;
        cfg        <= c;
        ifmap_base <= s.ifmap_base;
        ipsum_base <= s.ipsum_base;
        bias_base  <= s.bias_base;
        opsum_base <= s.opsum_base;
        is_bias    <= s.is_bias;
        @(negedge clk);
        check_fifo_rst(1'b1);

        // ipsum walks by tile_n from the bias or ipsum base
        // opsum walks by on_real
        exp_ifmap = ref_ifmap_bank(c, s.ifmap_base, exp_ifmap);
        exp_ipsum = ref_psum_bank(c, s.is_bias ? s.bias_base : s.ipsum_base, s.tile_n);
        exp_opsum = ref_psum_bank(c, s.opsum_base, s.on_real);
        @(posedge clk);
        @(negedge clk);
        check_fifo_rst(1'b1);
        check_banks();

        // leave init
        // psum banks clear one edge later
        @(posedge clk);
        init <= 1'b0;
        exp_ipsum = '0;
        exp_opsum = '0;
        @(posedge clk);
        @(negedge clk);
        check_fifo_rst(1'b0);
        check_banks();

        if (err_cnt != err_before) begin
            fail_cnt++;
        end
        $display("test %0d (%s): %s", cur_test, stim_name[idx],
                 (err_cnt == err_before) ? "ok" : "failed");
    endtask

    initial begin
        rst_n      = 1'b0;
        init       = 1'b0;
        cfg        = '0;
        ifmap_base = '0;
        ipsum_base = '0;
        bias_base  = '0;
        opsum_base = '0;
        is_bias    = 1'b0;
        err_cnt    = 0;
        fail_cnt   = 0;
        cur_test   = 0;
        exp_ifmap  = '0;
        exp_ipsum  = '0;
        exp_opsum  = '0;
        void'($urandom(SEED));

        // layer, bias, tile_n, in_c, on_real, out_row
        add_entry(0, "pw no bias", `L2C_PW, 1'b0, 32'd16, 8'd8, 32'd14, 32'sd0);
        add_entry(1, "pw bias", `L2C_PW, 1'b1, 32'd28, 8'd32, 32'd26, 32'sd3);
        add_entry(2, "dw row 0", `L2C_DW, 1'b0, 32'd12, 8'd4, 32'd10, 32'sd0);
        add_entry(3, "dw row 1", `L2C_DW, 1'b1, 32'd20, 8'd16, 32'd18, 32'sd1);
        add_entry(4, "dw row 5", `L2C_DW, 1'b0, 32'd56, 8'd64, 32'd54, 32'sd5);
        // standard type keeps the dw row 5 ifmap bank
        add_entry(5, "standard hold", 2'd2, 1'b1, 32'd7, 8'd3, 32'd5, 32'sd2);
        // products above 2^32 wrap
        add_entry(6, "pw wrap", `L2C_PW, 1'b0, 32'h0900_0000, 8'd255, 32'h0f00_0001, 32'sd0);
        add_entry(7, "dw wide", `L2C_DW, 1'b1, 32'h0100_0003, 8'd255, 32'h0000_ffff,
                  32'sd40000);
        add_entry(8, "linear hold", 2'd3, 1'b0, 32'd9, 8'd2, 32'd8, 32'sd1);

        // reset for 3 cycles
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_fifo_rst(1'b0);
        check_banks();
        if (err_cnt != 0) begin
            fail_cnt++;
        end
        $display("test 0 (after reset): %s", (err_cnt == 0) ? "ok" : "failed");

        for (int t = 0; t < NUM_TESTS; t++) begin
            run_entry(t);
        end

        $display("summary: %0d tests, %0d failed, %0d mismatches",
                 NUM_TESTS + 1, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+src
+incdir+verification
src/l2c_pkg.sv
src/ifmap_base_addr_gen.sv
src/psum_base_addr_gen.sv
src/l2c_fifo_base_init.sv
verification/tb_l2c_fifo_base_init.sv

// File: Bender.yml
package:
  name: l2c_fifo_base_init

sources:
  - include_dirs:
      - src
    files:
      - src/l2c_pkg.sv
      - src/ifmap_base_addr_gen.sv
      - src/psum_base_addr_gen.sv
      - src/l2c_fifo_base_init.sv
  - target: test
    include_dirs:
      - src
      - verification
    files:
      - verification/tb_l2c_fifo_base_init.sv
